//--- rtl/ptp_pkg.sv
package ptp_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and counts
	localparam int PORT_NUMBER = 4;
	localparam int DATA_WIDTH = 64;
	localparam int CTRL_WIDTH = 8;
	localparam int TIME_WIDTH = 64;
	localparam int TS_WIDTH = 80;
	localparam int MAC_WIDTH = 48;
	localparam int SYNC_INTERVAL_WIDTH = 16;
	localparam int SYNC_TIMEOUT_WIDTH = 16;
	localparam int LINK_DELAY_WIDTH = 32;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [CTRL_WIDTH-1:0] ctrl_t;
	typedef logic [PORT_NUMBER-1:0] port_mask_t;    // one bit per switch port
	typedef logic [TIME_WIDTH-1:0] time_t;
	typedef logic [TS_WIDTH-1:0] ts_t;
	typedef logic [MAC_WIDTH-1:0] mac_t;
	typedef logic [3:0] word_idx_t;

	//////////////////////////////////////////////////////////////////////
	// timing
	localparam logic [6:0] TICK_CYCLES = 7'd125;    // 125 x 8 ns = 1 us
	localparam time_t NS_PER_CYCLE = 64'd8;
	localparam time_t RESIDENCE_NS = 64'd5536;      // fixed residence term

	//////////////////////////////////////////////////////////////////////
	// sync frame layout
	localparam word_idx_t FRAME_WORDS = 4'd9;
	localparam ctrl_t CTRL_FIRST = 8'hFF;
	localparam ctrl_t CTRL_LAST = 8'h01;
	localparam ctrl_t CTRL_MID = 8'h00;
	localparam logic [15:0] ETHER_TYPE = 16'h88F7;
	localparam logic [15:0] PTP_VERSION_BYTE = 16'h0002;  // transport, type, rsvd, version
	localparam logic [15:0] MSG_LENGTH = 16'h002C;
	localparam logic [7:0] LOG_INTERVAL = 8'h7F;
	localparam logic [79:0] SOURCE_PORT_ID = 80'h0002_00FF_FE00_0001_0001;
	localparam mac_t MASTER_MAC_D = 48'h011B19000000;     // ptp multicast
	localparam mac_t MASTER_MAC_S = 48'h020000000001;

	localparam word_idx_t W_HEADER = 4'd0;
	localparam word_idx_t W_MAC = 4'd1;
	localparam word_idx_t W_MAC_ETH = 4'd2;
	localparam word_idx_t W_CORR_HI = 4'd3;
	localparam word_idx_t W_CORR_LO = 4'd4;
	localparam word_idx_t W_PORT_ID = 4'd5;
	localparam word_idx_t W_PORT_SEQ = 4'd6;
	localparam word_idx_t W_ORIGIN_HI = 4'd7;
	localparam word_idx_t W_ORIGIN_LO = 4'd8;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_WAIT_FIRST,
		RX_BODY
	} rx_state_t;

	typedef enum logic {
		TX_IDLE,
		TX_SEND
	} tx_state_t;

endpackage

//--- rtl/sync_interval_timer.sv
`timescale 1ns/100ps
module sync_interval_timer (
	input logic clk,
	input logic rst,
	input logic master,
	input logic slave,
	input logic [ptp_pkg::SYNC_INTERVAL_WIDTH-1:0] sync_interval,
	input logic [ptp_pkg::SYNC_TIMEOUT_WIDTH-1:0] sync_timeout,
	input logic rx_done,
	output logic sync_req,
	output logic sync_state
);
	import ptp_pkg::*;

	logic [$bits(TICK_CYCLES)-1:0] us_cnt;
	logic us_tick;
	logic [SYNC_INTERVAL_WIDTH-1:0] int_cnt;
	logic [SYNC_TIMEOUT_WIDTH-1:0] miss_cnt;    // intervals without a frame
	logic timed_out;

	assign us_tick = (us_cnt == TICK_CYCLES - 1'b1);
	assign timed_out = (miss_cnt == sync_timeout);

	// microsecond prescaler
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			us_cnt <= '0;
		end else if (us_tick) begin
			us_cnt <= '0;
		end else begin
			us_cnt <= us_cnt + 1'b1;
		end
	end

	// one strobe every sync_interval+1 ticks
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			int_cnt <= '0;
			sync_req <= 1'b0;
		end else begin
			sync_req <= 1'b0;
			if (us_tick) begin
				if (int_cnt >= sync_interval) begin   // >= so a lowered interval still wraps
					int_cnt <= '0;
					sync_req <= 1'b1;
				end else begin
					int_cnt <= int_cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// slave watchdog
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			miss_cnt <= '0;
		end else if (!slave || rx_done) begin
			miss_cnt <= '0;
		end else if (sync_req && !timed_out) begin
			miss_cnt <= miss_cnt + 1'b1;                // saturates at the limit
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sync_state <= 1'b0;
		end else begin
			sync_state <= master || (slave && !timed_out);
		end
	end

endmodule

//--- rtl/sync_frame_parser.sv
`timescale 1ns/100ps
module sync_frame_parser (
	input logic clk,
	input logic rst,
	input logic master,
	input ptp_pkg::port_mask_t rx_valid,
	input ptp_pkg::data_t rx_data,
	input ptp_pkg::ctrl_t rx_ctrl,
	input ptp_pkg::port_mask_t rx_wr,
	input logic tx_busy,
	output ptp_pkg::port_mask_t rx_rdy,
	output ptp_pkg::port_mask_t src_port,
	output logic rx_done,
	output ptp_pkg::data_t rx_header,
	output ptp_pkg::mac_t rx_mac_d,
	output ptp_pkg::mac_t rx_mac_s,
	output ptp_pkg::time_t rx_corr,
	output ptp_pkg::ts_t rx_origin,
	output logic [47:0] rx_trailer
);
	import ptp_pkg::*;

	rx_state_t state;
	word_idx_t word_idx;       // index of the next expected word
	port_mask_t lowest_req;
	logic word_ok;
	logic first_ok;

	// isolate the lowest requesting port
	assign lowest_req = rx_valid & (~rx_valid + 1'b1);

	// src_port stays put after rx_rdy drops, so word 8 is still seen
	assign word_ok = |(rx_wr & src_port);
	assign first_ok = word_ok && (rx_ctrl == CTRL_FIRST);

	//////////////////////////////////////////////////////////////////////
	// port select and word counting
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= RX_IDLE;
			word_idx <= '0;
			rx_rdy <= '0;
			src_port <= '0;
			rx_done <= 1'b0;
		end else if (master) begin
			state <= RX_IDLE;                // master never listens
			rx_rdy <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (!tx_busy && (|rx_valid)) begin
						rx_rdy <= lowest_req;
						src_port <= lowest_req;
						state <= RX_WAIT_FIRST;
					end
				end
				RX_WAIT_FIRST: begin
					if (first_ok) begin
						word_idx <= W_MAC;
						state <= RX_BODY;
					end
				end
				RX_BODY: begin
					if (word_ok) begin
						word_idx <= word_idx + 1'b1;
						if (word_idx == W_ORIGIN_HI) begin
							rx_rdy <= '0;          // sender may stop after this one
						end
						if (word_idx == FRAME_WORDS - 1'b1) begin
							rx_done <= 1'b1;
							state <= RX_IDLE;
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// field capture
	always_ff @(posedge clk) begin
		if (state == RX_WAIT_FIRST && first_ok) begin
			rx_header <= rx_data;
		end
		if (state == RX_BODY && word_ok) begin
			case (word_idx)
				W_MAC: begin
					rx_mac_d <= rx_data[63:16];
					rx_mac_s[47:32] <= rx_data[15:0];
				end
				W_MAC_ETH: rx_mac_s[31:0] <= rx_data[63:32];
				W_CORR_HI: rx_corr[63:48] <= rx_data[15:0];
				W_CORR_LO: rx_corr[47:0] <= rx_data[63:16];
				W_ORIGIN_HI: rx_origin[79:16] <= rx_data;
				W_ORIGIN_LO: begin
					rx_origin[15:0] <= rx_data[63:48];
					rx_trailer <= rx_data[47:0];
				end
				default: ;                       // constant words, nothing kept
			endcase
		end
	end

endmodule

//--- rtl/sync_time_keeper.sv
`timescale 1ns/100ps
module sync_time_keeper (
	input logic clk,
	input logic rst,
	input logic rx_done,
	input ptp_pkg::time_t rx_corr,
	input ptp_pkg::ts_t rx_origin,
	input logic [ptp_pkg::LINK_DELAY_WIDTH-1:0] link_delay,
	output ptp_pkg::time_t local_clk_counter,
	output ptp_pkg::time_t global_time
);
	import ptp_pkg::*;

	time_t load_val;
	logic load_pend;

	// four-term sum gets its own cycle
	always_ff @(posedge clk) begin
		if (rx_done) begin
			load_val <= rx_origin[TIME_WIDTH-1:0] + rx_corr
				+ {{(TIME_WIDTH-LINK_DELAY_WIDTH){1'b0}}, link_delay}
				+ RESIDENCE_NS;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			load_pend <= 1'b0;
			local_clk_counter <= '0;
			global_time <= '0;
		end else begin
			load_pend <= rx_done;
			local_clk_counter <= local_clk_counter + 1'b1;   // free running
			if (load_pend) begin
				global_time <= load_val;
			end else begin
				global_time <= global_time + NS_PER_CYCLE;
			end
		end
	end

endmodule

//--- rtl/sync_frame_builder.sv
`timescale 1ns/100ps
module sync_frame_builder (
	input logic clk,
	input logic rst,
	input logic master,
	input logic slave,
	input logic sync_req,
	input logic rx_done,
	input ptp_pkg::port_mask_t src_port,
	input ptp_pkg::port_mask_t udp_rdy,
	input ptp_pkg::time_t local_clk_counter,
	input ptp_pkg::time_t global_time,
	input logic [ptp_pkg::LINK_DELAY_WIDTH-1:0] link_delay,
	input ptp_pkg::data_t rx_header,
	input ptp_pkg::mac_t rx_mac_d,
	input ptp_pkg::mac_t rx_mac_s,
	input ptp_pkg::time_t rx_corr,
	input ptp_pkg::ts_t rx_origin,
	input logic [47:0] rx_trailer,
	output logic tx_busy,
	output logic [ptp_pkg::PORT_NUMBER*ptp_pkg::DATA_WIDTH-1:0] udp_data,
	output logic [ptp_pkg::PORT_NUMBER*ptp_pkg::CTRL_WIDTH-1:0] udp_ctrl,
	output ptp_pkg::port_mask_t udp_wr
);
	import ptp_pkg::*;

	tx_state_t tx_state;
	word_idx_t word_idx;
	logic m_trig;
	logic s_trig;
	data_t hdr_q;
	mac_t mac_d_q;
	mac_t mac_s_q;
	time_t corr_q;
	ts_t origin_q;
	logic [47:0] trailer_q;
	data_t word;
	ctrl_t word_ctrl;
	data_t word_q;
	ctrl_t ctrl_q;
	logic wr_q;
	port_mask_t port_en_q;

	assign m_trig = master && sync_req;
	assign s_trig = slave && !master && rx_done;   // master wins if both set
	assign tx_busy = (tx_state == TX_SEND);

	//////////////////////////////////////////////////////////////////////
	// sequencer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tx_state <= TX_IDLE;
			word_idx <= '0;
		end else begin
			case (tx_state)
				TX_IDLE: begin
					if (m_trig || s_trig) begin
						tx_state <= TX_SEND;
						word_idx <= W_HEADER;
					end
				end
				TX_SEND: begin
					word_idx <= word_idx + 1'b1;
					if (word_idx == FRAME_WORDS - 1'b1) begin
						tx_state <= TX_IDLE;
					end
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	// frame fields, latched once per trigger
	always_ff @(posedge clk) begin
		if (tx_state == TX_IDLE && m_trig) begin
			hdr_q <= local_clk_counter;
			mac_d_q <= MASTER_MAC_D;
			mac_s_q <= MASTER_MAC_S;
			corr_q <= '0;
			origin_q <= {{(TS_WIDTH-TIME_WIDTH){1'b0}}, global_time};
			trailer_q <= '0;
		end else if (tx_state == TX_IDLE && s_trig) begin
			hdr_q <= rx_header;
			mac_d_q <= rx_mac_d;
			mac_s_q <= rx_mac_s;
			corr_q <= rx_corr + {{(TIME_WIDTH-LINK_DELAY_WIDTH){1'b0}}, link_delay};
			origin_q <= rx_origin;
			trailer_q <= rx_trailer;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// word composition
	always_comb begin
		word = '0;
		word_ctrl = CTRL_MID;
		if (tx_busy) begin
			case (word_idx)
				W_HEADER: word = hdr_q;
				W_MAC: word = {mac_d_q, mac_s_q[47:32]};
				W_MAC_ETH: word = {mac_s_q[31:0], ETHER_TYPE, PTP_VERSION_BYTE};
				W_CORR_HI: word = {MSG_LENGTH, 32'h0, corr_q[63:48]};  // domain, flags zero
				W_CORR_LO: word = {corr_q[47:0], 16'h0};
				W_PORT_ID: word = {16'h0, SOURCE_PORT_ID[79:32]};
				W_PORT_SEQ: word = {SOURCE_PORT_ID[31:0], 16'h0, 8'h00, LOG_INTERVAL};
				W_ORIGIN_HI: word = origin_q[79:16];
				W_ORIGIN_LO: word = {origin_q[15:0], trailer_q};
				default: word = '0;
			endcase
			if (word_idx == W_HEADER) begin
				word_ctrl = CTRL_FIRST;
			end else if (word_idx == FRAME_WORDS - 1'b1) begin
				word_ctrl = CTRL_LAST;
			end
		end
	end

	always_ff @(posedge clk) begin
		word_q <= word;
		ctrl_q <= word_ctrl;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_q <= 1'b0;
			port_en_q <= '0;
		end else begin
			wr_q <= tx_busy;
			port_en_q <= master ? '1 : (slave ? ~src_port : '0);   // skip the source port
		end
	end

	// per-port gating, a word is dropped while udp_rdy is low
	for (genvar i = 0; i < PORT_NUMBER; i++) begin : g_port
		logic pass;
		assign pass = wr_q && port_en_q[i] && udp_rdy[i];
		assign udp_wr[i] = pass;
		assign udp_data[i*DATA_WIDTH +: DATA_WIDTH] = pass ? word_q : '0;
		assign udp_ctrl[i*CTRL_WIDTH +: CTRL_WIDTH] = pass ? ctrl_q : '0;
	end

endmodule

//--- rtl/ptp_sync_ctrl.sv
`timescale 1ns/100ps
module ptp_sync_ctrl (
	input logic clk,
	input logic rst,
	input logic master,
	input logic slave,
	input ptp_pkg::port_mask_t rx_valid,
	input ptp_pkg::data_t rx_data,
	input ptp_pkg::ctrl_t rx_ctrl,
	input ptp_pkg::port_mask_t rx_wr,
	input ptp_pkg::port_mask_t udp_rdy,
	input logic [ptp_pkg::SYNC_INTERVAL_WIDTH-1:0] sync_interval,
	input logic [ptp_pkg::SYNC_TIMEOUT_WIDTH-1:0] sync_timeout,
	input logic [ptp_pkg::LINK_DELAY_WIDTH-1:0] link_delay,
	output ptp_pkg::port_mask_t rx_rdy,
	output logic [ptp_pkg::PORT_NUMBER*ptp_pkg::DATA_WIDTH-1:0] udp_data,
	output logic [ptp_pkg::PORT_NUMBER*ptp_pkg::CTRL_WIDTH-1:0] udp_ctrl,
	output ptp_pkg::port_mask_t udp_wr,
	output ptp_pkg::time_t local_clk_counter,
	output ptp_pkg::time_t global_time,
	output logic sync_state
);
	import ptp_pkg::*;

	logic sync_req;
	logic tx_busy;
	logic rx_done;
	port_mask_t src_port;

	// captured sync record
	data_t rx_header;
	mac_t rx_mac_d;
	mac_t rx_mac_s;
	time_t rx_corr;
	ts_t rx_origin;
	logic [47:0] rx_trailer;

	sync_interval_timer timer_i (
		.clk(clk),
		.rst(rst),
		.master(master),
		.slave(slave),
		.sync_interval(sync_interval),
		.sync_timeout(sync_timeout),
		.rx_done(rx_done),
		.sync_req(sync_req),
		.sync_state(sync_state)
	);

	sync_frame_parser parser_i (
		.clk(clk),
		.rst(rst),
		.master(master),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_ctrl(rx_ctrl),
		.rx_wr(rx_wr),
		.tx_busy(tx_busy),
		.rx_rdy(rx_rdy),
		.src_port(src_port),
		.rx_done(rx_done),
		.rx_header(rx_header),
		.rx_mac_d(rx_mac_d),
		.rx_mac_s(rx_mac_s),
		.rx_corr(rx_corr),
		.rx_origin(rx_origin),
		.rx_trailer(rx_trailer)
	);

	sync_time_keeper keeper_i (
		.clk(clk),
		.rst(rst),
		.rx_done(rx_done),
		.rx_corr(rx_corr),
		.rx_origin(rx_origin),
		.link_delay(link_delay),
		.local_clk_counter(local_clk_counter),
		.global_time(global_time)
	);

	sync_frame_builder builder_i (
		.clk(clk),
		.rst(rst),
		.master(master),
		.slave(slave),
		.sync_req(sync_req),
		.rx_done(rx_done),
		.src_port(src_port),
		.udp_rdy(udp_rdy),
		.local_clk_counter(local_clk_counter),
		.global_time(global_time),
		.link_delay(link_delay),
		.rx_header(rx_header),
		.rx_mac_d(rx_mac_d),
		.rx_mac_s(rx_mac_s),
		.rx_corr(rx_corr),
		.rx_origin(rx_origin),
		.rx_trailer(rx_trailer),
		.tx_busy(tx_busy),
		.udp_data(udp_data),
		.udp_ctrl(udp_ctrl),
		.udp_wr(udp_wr)
	);

endmodule

//--- verif/ptp_sync_assert.sv
`timescale 1ns/100ps
module ptp_sync_assert (
	input logic clk,
	input logic rst,
	input ptp_pkg::port_mask_t sel,
	input logic tx_busy,
	input ptp_pkg::word_idx_t word_idx,
	input ptp_pkg::port_mask_t udp_wr,
	input logic [ptp_pkg::PORT_NUMBER*ptp_pkg::CTRL_WIDTH-1:0] udp_ctrl
);
	import ptp_pkg::*;

	logic first_out;    // some port shows CTRL_FIRST

	always_comb begin
		first_out = 1'b0;
		for (int i = 0; i < PORT_NUMBER; i++) begin
			if (udp_wr[i] && udp_ctrl[i*CTRL_WIDTH +: CTRL_WIDTH] == CTRL_FIRST) begin
				first_out = 1'b1;
			end
		end
	end

	// output lags the sequencer by one register
	first_ctrl_on_header: assert property (@(posedge clk) disable iff (rst)
		first_out |-> $past(tx_busy && word_idx == W_HEADER))
		else $error("CTRL_FIRST seen on a word other than the header");

	select_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
		else $error("rx_rdy selects more than one port");

	words_contiguous: assert property (@(posedge clk) disable iff (rst)
		(tx_busy && word_idx != FRAME_WORDS - 1'b1) |=>
			(tx_busy && word_idx == $past(word_idx) + 1'b1))
		else $error("frame words not sent back to back");

endmodule

bind sync_frame_parser ptp_sync_assert parser_chk (
	.clk(clk),
	.rst(rst),
	.sel(rx_rdy),
	.tx_busy(1'b0),
	.word_idx('0),
	.udp_wr('0),
	.udp_ctrl('0)
);

bind sync_frame_builder ptp_sync_assert builder_chk (
	.clk(clk),
	.rst(rst),
	.sel('0),
	.tx_busy(tx_busy),
	.word_idx(word_idx),
	.udp_wr(udp_wr),
	.udp_ctrl(udp_ctrl)
);

//--- verif/tb_ptp_sync.sv
`timescale 1ns/100ps
module tb_ptp_sync;
	import ptp_pkg::*;

	localparam int NUM_ROWS = 6;
	localparam int NUM_WORDS = int'(FRAME_WORDS);

	typedef struct {
		logic master;
		logic slave;
		port_mask_t rdy;
		port_mask_t valid;
		logic [8:0] gaps;          // bit w set, one idle cycle before word w
		logic [15:0] interval;
		logic [15:0] timeout;
		data_t header;
		mac_t mac_d;
		mac_t mac_s;
		time_t corr;
		ts_t origin;
		logic [47:0] trailer;
		logic [31:0] link;
		port_mask_t exp_sel;
		time_t exp_corr;
		time_t exp_load;
	} row_t;

	logic clk;
	logic rst;
	logic master;
	logic slave;
	port_mask_t rx_valid;
	data_t rx_data;
	ctrl_t rx_ctrl;
	port_mask_t rx_wr;
	port_mask_t udp_rdy;
	logic [SYNC_INTERVAL_WIDTH-1:0] sync_interval;
	logic [SYNC_TIMEOUT_WIDTH-1:0] sync_timeout;
	logic [LINK_DELAY_WIDTH-1:0] link_delay;
	port_mask_t rx_rdy;
	logic [PORT_NUMBER*DATA_WIDTH-1:0] udp_data;
	logic [PORT_NUMBER*CTRL_WIDTH-1:0] udp_ctrl;
	port_mask_t udp_wr;
	time_t local_clk_counter;
	time_t global_time;
	logic sync_state;

	row_t rows[NUM_ROWS];
	data_t frame_w[NUM_WORDS];
	data_t got_data[PORT_NUMBER][$];
	ctrl_t got_ctrl[PORT_NUMBER][$];
	data_t idle_data[$];           // values seen on a port with udp_wr low
	ctrl_t idle_ctrl[$];
	logic collect;
	int seed;
	int mismatches;
	int fails;

	ptp_sync_ctrl dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_time(input string name, input time_t got, input time_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_mask(input string name, input port_mask_t got, input port_mask_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			mismatches++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// frame layout and helpers
	task automatic build_frame(input data_t hdr, input mac_t mac_d, input mac_t mac_s,
			input time_t corr, input ts_t origin, input logic [47:0] trailer);
		frame_w[W_HEADER] = hdr;
		frame_w[W_MAC] = {mac_d, mac_s[47:32]};
		frame_w[W_MAC_ETH] = {mac_s[31:0], ETHER_TYPE, PTP_VERSION_BYTE};
		frame_w[W_CORR_HI] = {MSG_LENGTH, 32'h0, corr[63:48]};    // domain and flags zero
		frame_w[W_CORR_LO] = {corr[47:0], 16'h0};
		frame_w[W_PORT_ID] = {16'h0, SOURCE_PORT_ID[79:32]};
		frame_w[W_PORT_SEQ] = {SOURCE_PORT_ID[31:0], 16'h0, 8'h00, LOG_INTERVAL};
		frame_w[W_ORIGIN_HI] = origin[79:16];
		frame_w[W_ORIGIN_LO] = {origin[15:0], trailer};
	endtask

	function automatic ctrl_t ctrl_of(input int w);
		if (w == 0) begin
			return CTRL_FIRST;
		end else if (w == NUM_WORDS - 1) begin
			return CTRL_LAST;
		end
		return CTRL_MID;
	endfunction

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	function automatic logic probe(input int which);
		case (which)
			0: return dut_i.builder_i.tx_busy;
			1: return sync_state;
			default: return |rx_rdy;
		endcase
	endfunction

	task automatic wait_for(input int which, input logic level, input int limit,
			input string what);
		int n;
		n = 0;
		while (probe(which) !== level && n < limit) begin
			step();
			n++;
		end
		if (probe(which) !== level) begin
			$display("failure at %0t: timed out waiting for %s", $time, what);
			fails++;
		end
	endtask

	function automatic int row_cycles(input int r);
		return 80 + (int'(rows[r].timeout) + 2) * (int'(rows[r].interval) + 1)
			* int'(TICK_CYCLES);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	task automatic set_row(input int r, input logic m, input port_mask_t rdy,
			input port_mask_t vld, input logic [8:0] gaps, input logic [15:0] intv,
			input logic [15:0] tmo, input bit rnd);
		logic [63:0] a;
		logic [63:0] b;
		rows[r].master = m;
		rows[r].slave = !m;
		rows[r].rdy = rdy;
		rows[r].valid = vld;
		rows[r].gaps = gaps;
		rows[r].interval = intv;
		rows[r].timeout = tmo;
		rows[r].header = 64'h0123_4567_89AB_CDEF;
		rows[r].mac_d = 48'h0180_C200_000E;
		rows[r].mac_s = 48'h0A0B_0C0D_0E0F;
		rows[r].corr = 64'h0000_0000_0012_8000;
		rows[r].origin = 80'h0000_0000_0001_0000_0000;
		rows[r].trailer = 48'h0;
		rows[r].link = 32'd250;
		if (rnd) begin
			a = {$random(seed), $random(seed)};
			b = {$random(seed), $random(seed)};
			rows[r].header = a;
			rows[r].mac_d = b[47:0];
			rows[r].mac_s = {b[63:48], a[31:0]};
			a = {$random(seed), $random(seed)};
			b = {$random(seed), $random(seed)};
			rows[r].corr = a;
			rows[r].origin = {b[15:0], b};
			rows[r].trailer = b[63:16];
			a = {$random(seed), $random(seed)};
			rows[r].link = a[31:0];
		end
		// lowest requesting port wins
		rows[r].exp_sel = '0;
		for (int i = PORT_NUMBER - 1; i >= 0; i--) begin
			if (vld[i]) begin
				rows[r].exp_sel = port_mask_t'(1) << i;
			end
		end
		rows[r].exp_corr = rows[r].corr + {32'h0, rows[r].link};
		rows[r].exp_load = rows[r].origin[63:0] + rows[r].corr + {32'h0, rows[r].link}
			+ RESIDENCE_NS;
	endtask

	//////////////////////////////////////////////////////////////////////
	// output monitor
	always @(negedge clk) begin
		if (collect) begin
			for (int i = 0; i < PORT_NUMBER; i++) begin
				if (udp_wr[i]) begin
					got_data[i].push_back(udp_data[i*DATA_WIDTH +: DATA_WIDTH]);
					got_ctrl[i].push_back(udp_ctrl[i*CTRL_WIDTH +: CTRL_WIDTH]);
				end else if (udp_data[i*DATA_WIDTH +: DATA_WIDTH] != '0
						|| udp_ctrl[i*CTRL_WIDTH +: CTRL_WIDTH] != '0) begin
					idle_data.push_back(udp_data[i*DATA_WIDTH +: DATA_WIDTH]);
					idle_ctrl.push_back(udp_ctrl[i*CTRL_WIDTH +: CTRL_WIDTH]);
				end
			end
		end
	end

	task automatic check_ports(input int r);
		port_mask_t exp_ports;
		port_mask_t any_ports;
		port_mask_t full_ports;
		data_t hdr;
		exp_ports = rows[r].master ? rows[r].rdy : (rows[r].rdy & ~rows[r].exp_sel);
		for (int i = 0; i < PORT_NUMBER; i++) begin
			any_ports[i] = (got_data[i].size() != 0);
			full_ports[i] = (got_data[i].size() == NUM_WORDS);
		end
		check_mask("ports written", any_ports, exp_ports);
		check_mask("complete frames", full_ports, exp_ports);
		foreach (idle_data[k]) begin
			check_data("udp_data while udp_wr low", idle_data[k], '0);
			check_ctrl("udp_ctrl while udp_wr low", idle_ctrl[k], '0);
		end
		for (int i = 0; i < PORT_NUMBER; i++) begin
			if (full_ports[i]) begin
				hdr = got_data[i][0];
				if (rows[r].master) begin
					// no load since reset, so origin is 8 ns per counted cycle
					build_frame(hdr, MASTER_MAC_D, MASTER_MAC_S, '0,
						{16'h0, hdr * NS_PER_CYCLE}, '0);
				end else begin
					build_frame(rows[r].header, rows[r].mac_d, rows[r].mac_s,
						rows[r].exp_corr, rows[r].origin, rows[r].trailer);
				end
				for (int w = 0; w < NUM_WORDS; w++) begin
					check_data($sformatf("udp_data[%0d] word %0d", i, w), got_data[i][w],
						frame_w[w]);
					check_ctrl($sformatf("udp_ctrl[%0d] word %0d", i, w), got_ctrl[i][w],
						ctrl_of(w));
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one table row
	task automatic run_row(input int r);
		int limit;
		limit = (int'(rows[r].timeout) + 2) * (int'(rows[r].interval) + 1) * int'(TICK_CYCLES);
		rst = 1'b1;
		master = rows[r].master;
		slave = rows[r].slave;
		udp_rdy = rows[r].rdy;
		sync_interval = rows[r].interval;
		sync_timeout = rows[r].timeout;
		link_delay = rows[r].link;
		repeat (10) step();
		for (int i = 0; i < PORT_NUMBER; i++) begin
			got_data[i].delete();
			got_ctrl[i].delete();
		end
		idle_data.delete();
		idle_ctrl.delete();
		rst = 1'b0;
		collect = 1'b1;
		step();
		step();
		check_flag("sync_state", sync_state, 1'b1);
		// two edges counted since reset
		check_time("local_clk_counter", local_clk_counter, 64'd2);
		check_time("global_time", global_time, 2 * NS_PER_CYCLE);
		if (rows[r].slave) begin
			wait_for(1, 1'b0, limit, "sync_state to drop with no frames");
			build_frame(rows[r].header, rows[r].mac_d, rows[r].mac_s, rows[r].corr,
				rows[r].origin, rows[r].trailer);
			rx_valid = rows[r].valid;
			wait_for(2, 1'b1, limit, "rx_rdy after rx_valid");
			check_mask("rx_rdy", rx_rdy, rows[r].exp_sel);
			rx_valid = '0;
			for (int w = 0; w < NUM_WORDS; w++) begin
				if (rows[r].gaps[w]) begin
					rx_wr = '0;
					step();
				end
				rx_data = frame_w[w];
				rx_ctrl = ctrl_of(w);
				rx_wr = rows[r].exp_sel;
				step();
			end
			rx_wr = '0;
			rx_data = '0;
			rx_ctrl = '0;
			step();
			step();    // edge E+2 after the last word
			check_time("global_time", global_time, rows[r].exp_load);
			check_flag("sync_state", sync_state, 1'b1);
			step();
			check_time("global_time", global_time, rows[r].exp_load + NS_PER_CYCLE);
		end
		wait_for(0, 1'b1, limit, "frame transmit start");
		wait_for(0, 1'b0, limit, "frame transmit end");
		step();    // last word leaves the output register
		collect = 1'b0;
		check_ports(r);
	endtask

	initial begin
		seed = 95;
		mismatches = 0;
		fails = 0;
		collect = 1'b0;
		rst = 1'b1;
		master = 1'b0;
		slave = 1'b0;
		rx_valid = '0;
		rx_data = '0;
		rx_ctrl = '0;
		rx_wr = '0;
		udp_rdy = '0;
		sync_interval = '0;
		sync_timeout = '0;
		link_delay = '0;
		set_row(0, 1'b1, 4'b1111, 4'b0000, 9'h000, 16'd0, 16'd1, 1'b0);
		set_row(1, 1'b1, 4'b0101, 4'b0000, 9'h000, 16'd1, 16'd1, 1'b0);
		set_row(2, 1'b0, 4'b1111, 4'b0110, 9'h000, 16'd0, 16'd1, 1'b0);
		set_row(3, 1'b0, 4'b1011, 4'b1100, 9'b1_0101_0010, 16'd0, 16'd2, 1'b1);
		set_row(4, 1'b0, 4'b0110, 4'b1111, 9'b0_1000_1001, 16'd1, 16'd1, 1'b1);
		set_row(5, 1'b0, 4'b1111, 4'b1000, 9'h1FF, 16'd0, 16'd3, 1'b1);
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("summary: %0d mismatches, %0d other errors", mismatches, fails);
		if (mismatches == 0 && fails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog sized from the table
	initial begin
		int limit;
		#1;
		limit = 500;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += row_cycles(r);
		end
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limit);
		$display("Something failed");
		$finish;
	end

endmodule

//--- files.f
rtl/ptp_pkg.sv
rtl/sync_interval_timer.sv
rtl/sync_frame_parser.sv
rtl/sync_time_keeper.sv
rtl/sync_frame_builder.sv
rtl/ptp_sync_ctrl.sv
verif/ptp_sync_assert.sv
verif/tb_ptp_sync.sv

//--- run.sh
#!/bin/sh
# build and run the ptp sync testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_ptp_sync -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_ptp_sync)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
